// File: hw/cache_pkg.sv
package cache_pkg;

    // Address split: tag | index | word | byte
    localparam int TAG_W      = 5;
    localparam int INDEX_W    = 8;
    localparam int WORD_SEL_W = 2;
    localparam int WORD_W     = 16;

    localparam int LINE_WORDS = 1 << WORD_SEL_W;   // Words per line
    localparam int NUM_LINES  = 1 << INDEX_W;      // Lines in the cache

    typedef logic [WORD_W-1:0]     addr_t;         // Byte address
    typedef logic [WORD_W-1:0]     word_t;         // Data word
    typedef logic [TAG_W-1:0]      tag_t;          // Bits 15..11
    typedef logic [INDEX_W-1:0]    index_t;        // Bits 10..3
    typedef logic [WORD_SEL_W-1:0] word_sel_t;     // Bits 2..1, also the bank

endpackage

// File: hw/cache_array.sv
`timescale 1ns/1ps

module cache_array import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cache_en,
    input  logic      comp,
    input  logic      cache_wr,
    input  logic      fill,
    input  index_t    index,
    input  tag_t      tag,
    input  word_sel_t word_sel,
    input  word_t     wr_data,
    output word_t     rd_data,
    output logic      hit,
    output logic      dirty,
    output logic      valid,
    output tag_t      victim_tag
);

    tag_t                 tag_q   [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    word_t                data_q  [NUM_LINES][LINE_WORDS];

    logic                 cmp_wr;
    logic                 fill_wr;
    logic                 fill_last;

    // Combinational lookup of the selected line
    assign rd_data    = data_q[index][word_sel];
    assign valid      = valid_q[index];
    assign dirty      = dirty_q[index];
    assign victim_tag = tag_q[index];
    assign hit        = cache_en && comp && valid_q[index] && (tag_q[index] == tag);

    assign cmp_wr    = hit && cache_wr;               // Processor write, only on a hit
    assign fill_wr   = cache_en && fill;
    assign fill_last = fill_wr && (word_sel == word_sel_t'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_last) begin
                valid_q[index] <= 1'b1;           // Line complete
                dirty_q[index] <= 1'b0;
            end else if (cmp_wr) begin
                dirty_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr || cmp_wr) begin
            data_q[index][word_sel] <= wr_data;
        end
        if (fill_last) begin
            tag_q[index] <= tag;
        end
    end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // Processor side
    input  addr_t     addr,
    input  word_t     data_in,
    input  logic      rd,
    input  logic      wr,
    output word_t     data_out,
    output logic      done,
    output logic      hit_out,
    output logic      busy,
    // Cache array side
    output logic      cache_en,
    output logic      comp,
    output logic      cache_wr,
    output logic      fill,
    output index_t    index,
    output tag_t      tag,
    output word_sel_t word_sel,
    output word_t     wr_data,
    input  word_t     rd_data,
    input  logic      hit,
    input  logic      dirty,
    input  logic      valid,
    input  tag_t      victim_tag,
    // Memory side
    output logic      mem_rd,
    output logic      mem_wr,
    output addr_t     mem_addr,
    output word_t     mem_data_wr,
    input  logic      mem_stall,
    input  word_t     mem_data_rd,
    input  logic      mem_rd_valid
);

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        CHECK_DIRTY,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        DONE
    } state_t;

    state_t    state, state_nxt;

    tag_t      req_tag;                       // Latched request fields
    index_t    req_index;
    word_sel_t req_word;
    word_t     req_data;
    logic      req_wr;

    word_sel_t req_cnt;                       // Next word to send to memory
    word_sel_t ret_cnt;                       // Next fill word expected back
    logic      first_cmp;                     // Still on the first lookup
    logic      hit_q;
    word_t     data_out_q;

    logic      accept;
    logic      mem_req;
    tag_t      mem_tag;

    assign accept  = !busy && (rd || wr);
    assign mem_req = mem_rd || mem_wr;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:        if (rd || wr) state_nxt = COMPARE;
            COMPARE:     state_nxt = hit ? DONE : CHECK_DIRTY;
            CHECK_DIRTY: state_nxt = (valid && dirty) ? WRITEBACK : FILL_REQ;
            WRITEBACK:   if (!mem_stall && req_cnt == 2'd3) state_nxt = FILL_REQ;
            FILL_REQ:    if (!mem_stall && req_cnt == 2'd3) state_nxt = FILL_WAIT;
            FILL_WAIT:   if (mem_rd_valid && ret_cnt == 2'd3) state_nxt = COMPARE;
            DONE:        state_nxt = (rd || wr) ? COMPARE : IDLE; // Back to back request
            default:     state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            req_cnt   <= '0;
            ret_cnt   <= '0;
            first_cmp <= 1'b0;
            hit_q     <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                first_cmp <= 1'b1;
            end
            if (state == COMPARE) begin
                first_cmp <= 1'b0;
                if (first_cmp) hit_q <= hit;  // Later lookups always hit
            end
            if (state == CHECK_DIRTY) begin
                req_cnt <= '0;
                ret_cnt <= '0;
            end
            if (mem_req && !mem_stall) begin
                req_cnt <= req_cnt + 2'd1;    // Wraps to 0 between writeback and fill
            end
            if (fill) begin
                ret_cnt <= ret_cnt + 2'd1;
            end
        end
    end

    // Request payload and read result
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= addr[15:11];
            req_index <= addr[10:3];
            req_word  <= addr[2:1];
            req_data  <= data_in;
            req_wr    <= wr;
        end
        if (state == COMPARE && hit) begin
            data_out_q <= rd_data;
        end
    end

    assign busy     = (state != IDLE) && (state != DONE);
    assign done     = (state == DONE);
    assign hit_out  = done && hit_q;
    assign data_out = data_out_q;

    // Fill returns can overlap the tail of FILL_REQ
    assign fill     = mem_rd_valid && (state == FILL_REQ || state == FILL_WAIT);
    assign comp     = (state == COMPARE);
    assign cache_wr = comp && req_wr;
    assign cache_en = comp || fill || state == CHECK_DIRTY || state == WRITEBACK;
    assign index    = req_index;
    assign tag      = req_tag;
    assign wr_data  = fill ? mem_data_rd : req_data;

    always_comb begin
        case (state)
            WRITEBACK:           word_sel = req_cnt;
            FILL_REQ, FILL_WAIT: word_sel = ret_cnt;
            default:             word_sel = req_word;
        endcase
    end

    assign mem_wr      = (state == WRITEBACK);
    assign mem_rd      = (state == FILL_REQ);
    assign mem_tag     = mem_wr ? victim_tag : req_tag;   // Victim line or new line
    assign mem_addr    = {mem_tag, req_index, req_cnt, 1'b0};
    assign mem_data_wr = rd_data;                         // Stable while stalled

endmodule

// File: hw/main_mem.sv
`timescale 1ns/1ps

module main_mem import cache_pkg::*; #(
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  mem_rd,
    input  logic  mem_wr,
    input  addr_t mem_addr,
    input  word_t mem_data_wr,
    output logic  mem_stall,
    output word_t mem_data_rd,
    output logic  mem_rd_valid
);

    localparam int BANK_ROWS = 8192;                  // 32K words over four banks
    localparam int CNT_W     = $clog2(MEM_LATENCY + 1);

    word_t             bank_mem [LINE_WORDS][BANK_ROWS] = '{default: '0};
    logic [CNT_W-1:0]  busy_cnt [LINE_WORDS];

    logic [MEM_LATENCY-1:0] vld_pipe;                 // Read return line
    word_t                  data_pipe [MEM_LATENCY];

    word_sel_t         bank;
    logic [12:0]       row;
    logic              rd_acc;
    logic              wr_acc;

    assign bank      = mem_addr[2:1];
    assign row       = mem_addr[15:3];
    assign mem_stall = (busy_cnt[bank] != '0);
    assign rd_acc    = mem_rd && !mem_stall;
    assign wr_acc    = mem_wr && !mem_stall;

    // Per bank busy countdown
    always_ff @(posedge clk) begin
        for (int b = 0; b < LINE_WORDS; b++) begin
            if (reset) begin
                busy_cnt[b] <= '0;
            end else if ((rd_acc || wr_acc) && bank == word_sel_t'(b)) begin
                busy_cnt[b] <= CNT_W'(MEM_LATENCY);
            end else if (busy_cnt[b] != '0) begin
                busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            bank_mem[bank][row] <= mem_data_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[MEM_LATENCY-2:0], rd_acc};
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= bank_mem[bank][row];          // Sampled at acceptance
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign mem_rd_valid = vld_pipe[MEM_LATENCY-1];
    assign mem_data_rd  = data_pipe[MEM_LATENCY-1];

endmodule

// File: hw/mem_cache_top.sv
`timescale 1ns/1ps

module mem_cache_top import cache_pkg::*; #(
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  addr_t addr,
    input  word_t data_in,
    input  logic  rd,
    input  logic  wr,
    output word_t data_out,
    output logic  done,
    output logic  hit,
    output logic  busy
);

    logic      cache_en, comp, cache_wr, fill;
    index_t    index;
    tag_t      tag;
    word_sel_t word_sel;
    word_t     wr_data;
    word_t     rd_data;
    logic      cache_hit, dirty, valid;
    tag_t      victim_tag;

    logic      mem_rd, mem_wr, mem_stall, mem_rd_valid;
    addr_t     mem_addr;
    word_t     mem_data_wr, mem_data_rd;

    cache_ctrl cache_ctrl_i (
        .clk, .reset, .addr, .data_in, .rd, .wr, .data_out, .done,
        .hit_out (hit),
        .busy, .cache_en, .comp, .cache_wr, .fill, .index, .tag, .word_sel,
        .wr_data, .rd_data,
        .hit     (cache_hit),
        .dirty, .valid, .victim_tag, .mem_rd, .mem_wr, .mem_addr,
        .mem_data_wr, .mem_stall, .mem_data_rd, .mem_rd_valid
    );

    cache_array cache_array_i (
        .clk, .reset, .cache_en, .comp, .cache_wr, .fill, .index, .tag,
        .word_sel, .wr_data, .rd_data,
        .hit     (cache_hit),
        .dirty, .valid, .victim_tag
    );

    main_mem #(.MEM_LATENCY(MEM_LATENCY)) main_mem_i (
        .clk, .reset, .mem_rd, .mem_wr, .mem_addr, .mem_data_wr,
        .mem_stall, .mem_data_rd, .mem_rd_valid
    );

endmodule

// File: tb/mem_cache_sva.sv
`timescale 1ns/1ps

module mem_cache_sva import cache_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  rd,
    input logic  wr,
    input logic  busy,
    input logic  done,
    input logic  hit,
    input logic  hit_out,
    input logic  mem_rd,
    input logic  mem_wr,
    input logic  mem_stall,
    input addr_t mem_addr,
    input word_t mem_data_wr
);

    int unsigned fail_count = 0;              // Failed assertions so far

    // Memory request is either a read or a write
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(mem_rd && mem_wr))
        else begin
            fail_count++;
            $error("mem_rd and mem_wr high together");
        end

    // Back-pressure holds the request
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (mem_rd || mem_wr) && mem_stall |=>
            $stable(mem_rd) && $stable(mem_wr) && $stable(mem_addr) &&
            (!mem_wr || $stable(mem_data_wr)))
        else begin
            fail_count++;
            $error("Request changed while mem_stall was high");
        end

    a_reset_idle: assert property (@(posedge clk) reset |=> !done && !busy)
        else begin
            fail_count++;
            $error("done or busy high right after reset");
        end

    // Strobe, then a hit in COMPARE, then done
    a_hit_timing: assert property (@(posedge clk) disable iff (reset)
        (!busy && (rd || wr)) ##1 hit |-> !done ##1 (done && hit_out))
        else begin
            fail_count++;
            $error("Hit access did not finish two cycles after the strobe");
        end

endmodule

bind cache_ctrl mem_cache_sva ctrl_sva_i (
    .clk, .reset, .rd, .wr, .busy, .done, .hit, .hit_out,
    .mem_rd, .mem_wr, .mem_stall, .mem_addr, .mem_data_wr
);

// File: tb/tb_mem_cache.sv
`timescale 1ns/1ps

module tb_mem_cache import cache_pkg::*; ();

    localparam int MAX_CYCLES = 20000;        // ~300 requests at ~25 cycles worst case
    localparam int NUM_RANDOM = 300;

    logic  clk = 1'b0;
    logic  reset;
    addr_t addr;
    word_t data_in;
    logic  rd, wr;
    word_t data_out;
    logic  done, hit, busy;

    word_t ref_mem  [32768];                  // Word-memory model, by addr[15:1]
    tag_t  last_tag [NUM_LINES];              // Tag model per index
    logic  seen     [NUM_LINES];
    int    cycles = 0;
    int    stall_cycles = 0;

    mem_cache_top #(.MEM_LATENCY(4)) mem_cache_top_i (.*);

    always #2 clk = ~clk;

    // Cycle limit, stall count and bound assertion status
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (mem_cache_top_i.mem_stall && (mem_cache_top_i.mem_rd || mem_cache_top_i.mem_wr))
            stall_cycles = stall_cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end else if (mem_cache_top_i.cache_ctrl_i.ctrl_sva_i.fail_count != 0) begin
            $display("A bound controller assertion failed at %0t", $time);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string name, input word_t exp_val, input word_t act_val);
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic run_access(input logic is_wr, input addr_t a, input word_t d);
        logic  exp_hit;
        word_t exp_data;
        exp_hit  = seen[a[10:3]] && (last_tag[a[10:3]] == a[15:11]);
        exp_data = ref_mem[a[15:1]];
        seen[a[10:3]]     = 1'b1;               // Every access allocates its line
        last_tag[a[10:3]] = a[15:11];
        if (is_wr)
            ref_mem[a[15:1]] = d;
        @(posedge clk);
        #1;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        addr    = a;
        data_in = d;
        rd      = !is_wr;
        wr      = is_wr;
        @(posedge clk);
        #1;
        rd = 1'b0;
        wr = 1'b0;
        @(negedge clk);
        while (!done) @(negedge clk);
        assert (hit == exp_hit) else report_mismatch("hit", word_t'(exp_hit), word_t'(hit));
        if (!is_wr) begin
            assert (data_out == exp_data) else report_mismatch("data_out", exp_data, data_out);
        end
    endtask

    initial begin
        addr_t a;
        logic  w;
        int    stalls_before;
        void'($urandom(32'he946));
        reset   = 1'b1;
        addr    = '0;
        data_in = '0;
        rd      = 1'b0;
        wr      = 1'b0;
        for (int i = 0; i < 32768; i++) ref_mem[i] = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            seen[i]     = 1'b0;
            last_tag[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!done) else report_mismatch("done", '0, word_t'(done));
        assert (!busy) else report_mismatch("busy", '0, word_t'(busy));
        assert (!mem_cache_top_i.mem_rd) else report_mismatch("mem_rd", '0, 16'd1);
        assert (!mem_cache_top_i.mem_wr) else report_mismatch("mem_wr", '0, 16'd1);

        run_access(1'b0, 16'h1234, '0);          // Cold read returns zero
        run_access(1'b1, 16'h2A10, 16'hBEEF);
        run_access(1'b0, 16'h2A10, '0);          // Read hit after write

        // A and B share index 0x20
        run_access(1'b1, 16'h1902, 16'hA5A5);
        run_access(1'b1, 16'h4904, 16'h5A5A);
        stalls_before = stall_cycles;
        run_access(1'b0, 16'h1902, '0);
        assert (stall_cycles > stalls_before) else begin
            $display("Dirty eviction completed without any memory stall");
            $display("Simulation failed");
            $fatal(1);
        end

        // Full line written, evicted, then refilled by one miss
        for (int k = 0; k < LINE_WORDS; k++)
            run_access(1'b1, 16'h2A00 + addr_t'(2 * k), word_t'(16'h1000 + k));
        run_access(1'b0, 16'h3200, '0);
        for (int k = 0; k < LINE_WORDS; k++)
            run_access(1'b0, 16'h2A00 + addr_t'(2 * k), '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            a = {tag_t'($urandom % 4), index_t'(8'h10 + $urandom % 4),
                 word_sel_t'($urandom), 1'($urandom)};
            w = 1'($urandom);
            run_access(w, a, word_t'($urandom));
        end

        repeat (3) @(posedge clk);
        if (mem_cache_top_i.cache_ctrl_i.ctrl_sva_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
hw/cache_pkg.sv
hw/cache_array.sv
hw/cache_ctrl.sv
hw/main_mem.sv
hw/mem_cache_top.sv
tb/mem_cache_sva.sv
tb/tb_mem_cache.sv

// File: Makefile
TOP = tb_mem_cache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f build.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "RESULT: FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log || (echo "RESULT: FAIL"; exit 1)
	@echo "RESULT: PASS"

lint:
	verilator --lint-only -Wall --top-module mem_cache_top hw/cache_pkg.sv hw/cache_array.sv hw/cache_ctrl.sv hw/main_mem.sv hw/mem_cache_top.sv

clean:
	rm -rf obj_dir sim.log
